// ==== logic/geofence_pkg.sv ====
/*
 * Shared types and default sizes for the geofence checker.
 * Coordinates are unsigned. Only convex vertex sets are judged correctly.
 */
package geofence_pkg;

    // coordinate width in bits
    localparam int DEFAULT_COORD_W = 10;

    // receiver points that form the polygon
    localparam int DEFAULT_NUM_VERTICES = 6;

    // top-level sequence of one run
    typedef enum logic [2:0] {
        IDLE,
        READ,
        SORT,
        EDGE,
        OUT
    } ctrl_state_t;

    // three cycles per cross-product compare
    // MUL_A and MUL_B share one multiplier, DECIDE uses both terms
    typedef enum logic [1:0] {
        MUL_A,
        MUL_B,
        DECIDE
    } phase_t;

endpackage

// ==== logic/geofence_ctrl.sv ====
/*
 * Phase FSM of the geofence checker.
 * ready marks the cycles where a point is sampled, there is no host stall.
 * valid pulses for one cycle in OUT, then a new set is read.
 */
module geofence_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read_last,
    input  logic                      sort_last,
    input  logic                      edge_last,
    output geofence_pkg::ctrl_state_t state,
    output logic                      ready,
    output logic                      valid
);

    geofence_pkg::ctrl_state_t next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= geofence_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            geofence_pkg::IDLE: begin
                next_state = geofence_pkg::READ;
            end
            geofence_pkg::READ: begin
                // target plus every vertex taken
                if (read_last) begin
                    next_state = geofence_pkg::SORT;
                end
            end
            geofence_pkg::SORT: begin
                if (sort_last) begin
                    next_state = geofence_pkg::EDGE;
                end
            end
            geofence_pkg::EDGE: begin
                if (edge_last) begin
                    next_state = geofence_pkg::OUT;
                end
            end
            geofence_pkg::OUT: begin
                // straight back to reading, no idle gap
                next_state = geofence_pkg::READ;
            end
            default: begin
                next_state = geofence_pkg::IDLE;
            end
        endcase
    end

    assign ready = (state == geofence_pkg::READ);
    assign valid = (state == geofence_pkg::OUT);

    // result pulse is never stretched
    a_valid_single: assert property (
        @(posedge clk) disable iff (reset)
        valid |=> !valid
    ) else $error("valid held for more than one cycle");

    a_state_legal: assert property (
        @(posedge clk) disable iff (reset)
        state inside {geofence_pkg::IDLE, geofence_pkg::READ, geofence_pkg::SORT,
                      geofence_pkg::EDGE, geofence_pkg::OUT}
    ) else $error("illegal controller state");

endmodule

// ==== logic/geofence_step_counter.sv ====
/*
 * Counters that pace the controller phases.
 * SORT walks pairs (i,j) with 1 <= i < j <= N-1, vertex 0 is the pivot.
 * Needs NUM_VERTICES of at least 3.
 */
module geofence_step_counter #(
    parameter  int NUM_VERTICES = geofence_pkg::DEFAULT_NUM_VERTICES,
    localparam int IDX_W        = $clog2(NUM_VERTICES + 1)
) (
    input  logic                      clk,
    input  logic                      reset,
    input  geofence_pkg::ctrl_state_t state,
    output geofence_pkg::phase_t      phase,
    output logic [IDX_W-1:0]          point_idx,
    output logic [IDX_W-1:0]          pair_i,
    output logic [IDX_W-1:0]          pair_j,
    output logic                      read_last,
    output logic                      sort_last,
    output logic                      edge_last
);

    logic in_compare;
    logic decide;

    assign in_compare = (state == geofence_pkg::SORT) || (state == geofence_pkg::EDGE);
    assign decide     = (phase == geofence_pkg::DECIDE);

    assign read_last = (state == geofence_pkg::READ) && (point_idx == IDX_W'(NUM_VERTICES));
    assign sort_last = (state == geofence_pkg::SORT) && decide
                       && (pair_i == IDX_W'(NUM_VERTICES - 2))
                       && (pair_j == IDX_W'(NUM_VERTICES - 1));
    assign edge_last = (state == geofence_pkg::EDGE) && decide
                       && (point_idx == IDX_W'(NUM_VERTICES - 1));

    // three-cycle divider, parked on MUL_A outside the compare phases
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= geofence_pkg::MUL_A;
        end else if (!in_compare) begin
            phase <= geofence_pkg::MUL_A;
        end else begin
            case (phase)
                geofence_pkg::MUL_A: phase <= geofence_pkg::MUL_B;
                geofence_pkg::MUL_B: phase <= geofence_pkg::DECIDE;
                default:             phase <= geofence_pkg::MUL_A;
            endcase
        end
    end

    // read index in READ, edge index in EDGE
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            point_idx <= '0;
        end else if (state == geofence_pkg::READ) begin
            point_idx <= read_last ? '0 : point_idx + 1'b1;
        end else if (state == geofence_pkg::EDGE) begin
            if (decide) begin
                point_idx <= edge_last ? '0 : point_idx + 1'b1;
            end
        end else begin
            point_idx <= '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pair_i <= IDX_W'(1);
            pair_j <= IDX_W'(2);
        end else if (state == geofence_pkg::SORT && decide) begin
            if (sort_last) begin
                pair_i <= IDX_W'(1);
                pair_j <= IDX_W'(2);
            end else if (pair_j == IDX_W'(NUM_VERTICES - 1)) begin
                // next row of the pair triangle
                pair_i <= pair_i + 1'b1;
                pair_j <= pair_i + 2'd2;
            end else begin
                pair_j <= pair_j + 1'b1;
            end
        end
    end

    a_pair_order: assert property (
        @(posedge clk) disable iff (reset)
        pair_i < pair_j
    ) else $error("sort pair out of order");

endmodule

// ==== logic/vertex_store.sv ====
/*
 * Target and vertex registers with in-place sort swaps.
 * Difference vectors are one bit wider than a coordinate and signed.
 * Stored points carry no reset, the READ phase fills them.
 */
module vertex_store #(
    parameter  int COORD_W      = geofence_pkg::DEFAULT_COORD_W,
    parameter  int NUM_VERTICES = geofence_pkg::DEFAULT_NUM_VERTICES,
    localparam int IDX_W        = $clog2(NUM_VERTICES + 1)
) (
    input  logic                      clk,
    input  logic [COORD_W-1:0]        x,
    input  logic [COORD_W-1:0]        y,
    input  geofence_pkg::ctrl_state_t state,
    input  geofence_pkg::phase_t      phase,
    input  logic [IDX_W-1:0]          point_idx,
    input  logic [IDX_W-1:0]          pair_i,
    input  logic [IDX_W-1:0]          pair_j,
    input  logic                      positive,
    output logic signed [COORD_W:0]   u_x,
    output logic signed [COORD_W:0]   u_y,
    output logic signed [COORD_W:0]   w_x,
    output logic signed [COORD_W:0]   w_y
);

    logic [COORD_W-1:0] target_x;
    logic [COORD_W-1:0] target_y;
    logic [COORD_W-1:0] vx [NUM_VERTICES];
    logic [COORD_W-1:0] vy [NUM_VERTICES];
    logic [IDX_W-1:0]   edge_k;
    logic [IDX_W-1:0]   edge_n;

    function automatic logic signed [COORD_W:0] diff(
        input logic [COORD_W-1:0] a,
        input logic [COORD_W-1:0] b
    );
        return $signed({1'b0, a}) - $signed({1'b0, b});
    endfunction

    always_ff @(posedge clk) begin
        if (state == geofence_pkg::READ) begin
            // first sample of a run is the target
            if (point_idx == '0) begin
                target_x <= x;
                target_y <= y;
            end else begin
                vx[point_idx - 1'b1] <= x;
                vy[point_idx - 1'b1] <= y;
            end
        end else if (state == geofence_pkg::SORT && phase == geofence_pkg::DECIDE
                     && !positive) begin
            // j lies clockwise of i around v0, so exchange them
            vx[pair_i] <= vx[pair_j];
            vx[pair_j] <= vx[pair_i];
            vy[pair_i] <= vy[pair_j];
            vy[pair_j] <= vy[pair_i];
        end
    end

    // clamp keeps the read index of READ away from the array bounds
    assign edge_k = (point_idx < IDX_W'(NUM_VERTICES)) ? point_idx : '0;
    assign edge_n = (edge_k == IDX_W'(NUM_VERTICES - 1)) ? '0 : edge_k + 1'b1;

    always_comb begin
        if (state == geofence_pkg::SORT) begin
            u_x = diff(vx[pair_i], vx[0]);
            u_y = diff(vy[pair_i], vy[0]);
            w_x = diff(vx[pair_j], vx[0]);
            w_y = diff(vy[pair_j], vy[0]);
        end else begin
            // edge k against the target
            u_x = diff(vx[edge_k], target_x);
            u_y = diff(vy[edge_k], target_y);
            w_x = diff(vx[edge_n], vx[edge_k]);
            w_y = diff(vy[edge_n], vy[edge_k]);
        end
    end

endmodule

// ==== logic/cross_product_unit.sv ====
/*
 * Sign of the cross product u x w with one shared multiplier.
 * positive is only meaningful in DECIDE, a zero product reads as not positive.
 */
module cross_product_unit #(
    parameter  int COORD_W = geofence_pkg::DEFAULT_COORD_W,
    localparam int PROD_W  = 2 * COORD_W + 2
) (
    input  logic                    clk,
    input  geofence_pkg::phase_t    phase,
    input  logic signed [COORD_W:0] u_x,
    input  logic signed [COORD_W:0] u_y,
    input  logic signed [COORD_W:0] w_x,
    input  logic signed [COORD_W:0] w_y,
    output logic                    positive
);

    logic signed [COORD_W:0]  mul_l;
    logic signed [COORD_W:0]  mul_r;
    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] term_a;
    logic signed [PROD_W-1:0] term_b;

    // u_x*w_y first, then u_y*w_x
    assign mul_l = (phase == geofence_pkg::MUL_A) ? u_x : u_y;
    assign mul_r = (phase == geofence_pkg::MUL_A) ? w_y : w_x;

    assign product = mul_l * mul_r;

    always_ff @(posedge clk) begin
        if (phase == geofence_pkg::MUL_A) begin
            term_a <= product;
        end else if (phase == geofence_pkg::MUL_B) begin
            term_b <= product;
        end
    end

    // compare terms instead of subtracting, no extra width needed
    assign positive = (term_a > term_b);

    a_no_skip_a: assert property (
        @(posedge clk)
        phase == geofence_pkg::MUL_A |=> phase != geofence_pkg::DECIDE
    ) else $error("phase jumped from MUL_A to DECIDE");

    a_no_skip_b: assert property (
        @(posedge clk)
        phase == geofence_pkg::MUL_B |=> phase == geofence_pkg::DECIDE
    ) else $error("second product not followed by DECIDE");

    a_no_skip_d: assert property (
        @(posedge clk)
        phase == geofence_pkg::DECIDE |=> phase == geofence_pkg::MUL_A
    ) else $error("DECIDE not followed by MUL_A");

endmodule

// ==== logic/side_judge.sv ====
/*
 * Collects one sign per polygon edge and forms is_inside.
 * is_inside updates at the last edge and clears when the next EDGE phase starts.
 */
module side_judge #(
    parameter  int NUM_VERTICES = geofence_pkg::DEFAULT_NUM_VERTICES,
    localparam int IDX_W        = $clog2(NUM_VERTICES + 1)
) (
    input  logic                      clk,
    input  logic                      reset,
    input  geofence_pkg::ctrl_state_t state,
    input  geofence_pkg::phase_t      phase,
    input  logic [IDX_W-1:0]          point_idx,
    input  logic                      positive,
    output logic                      is_inside
);

    logic [NUM_VERTICES-1:0] signs;
    logic [NUM_VERTICES-1:0] signs_next;
    logic                    edge_entry;
    logic                    edge_decide;

    assign edge_entry  = (state == geofence_pkg::EDGE) && (phase == geofence_pkg::MUL_A)
                         && (point_idx == '0);
    assign edge_decide = (state == geofence_pkg::EDGE) && (phase == geofence_pkg::DECIDE);

    // vector as it will look after this edge is recorded
    always_comb begin
        signs_next = signs;
        if (point_idx < IDX_W'(NUM_VERTICES)) begin
            signs_next[point_idx] = positive;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            signs     <= '0;
            is_inside <= 1'b0;
        end else if (edge_entry) begin
            signs     <= '0;
            is_inside <= 1'b0;
        end else if (edge_decide) begin
            signs <= signs_next;
            // same side of every edge means inside
            if (point_idx == IDX_W'(NUM_VERTICES - 1)) begin
                is_inside <= (&signs_next) || (~|signs_next);
            end
        end
    end

endmodule

// ==== logic/geofence.sv ====
/*
 * Geofence checker top level.
 * One target then NUM_VERTICES vertices are read on the ready cycles.
 * The host must present a point on every ready cycle.
 */
module geofence #(
    parameter  int COORD_W      = geofence_pkg::DEFAULT_COORD_W,
    parameter  int NUM_VERTICES = geofence_pkg::DEFAULT_NUM_VERTICES,
    localparam int IDX_W        = $clog2(NUM_VERTICES + 1)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [COORD_W-1:0] x,
    input  logic [COORD_W-1:0] y,
    output logic               ready,
    output logic               valid,
    output logic               is_inside
);

    geofence_pkg::ctrl_state_t state;
    geofence_pkg::phase_t      phase;
    logic [IDX_W-1:0]          point_idx;
    logic [IDX_W-1:0]          pair_i;
    logic [IDX_W-1:0]          pair_j;
    logic                      read_last;
    logic                      sort_last;
    logic                      edge_last;
    logic signed [COORD_W:0]   u_x;
    logic signed [COORD_W:0]   u_y;
    logic signed [COORD_W:0]   w_x;
    logic signed [COORD_W:0]   w_y;
    logic                      positive;

    geofence_ctrl ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .read_last (read_last),
        .sort_last (sort_last),
        .edge_last (edge_last),
        .state     (state),
        .ready     (ready),
        .valid     (valid)
    );

    geofence_step_counter #(
        .NUM_VERTICES (NUM_VERTICES)
    ) step_counter_i (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .phase     (phase),
        .point_idx (point_idx),
        .pair_i    (pair_i),
        .pair_j    (pair_j),
        .read_last (read_last),
        .sort_last (sort_last),
        .edge_last (edge_last)
    );

    vertex_store #(
        .COORD_W      (COORD_W),
        .NUM_VERTICES (NUM_VERTICES)
    ) vertex_store_i (
        .clk       (clk),
        .x         (x),
        .y         (y),
        .state     (state),
        .phase     (phase),
        .point_idx (point_idx),
        .pair_i    (pair_i),
        .pair_j    (pair_j),
        .positive  (positive),
        .u_x       (u_x),
        .u_y       (u_y),
        .w_x       (w_x),
        .w_y       (w_y)
    );

    cross_product_unit #(
        .COORD_W (COORD_W)
    ) cross_product_i (
        .clk      (clk),
        .phase    (phase),
        .u_x      (u_x),
        .u_y      (u_y),
        .w_x      (w_x),
        .w_y      (w_y),
        .positive (positive)
    );

    side_judge #(
        .NUM_VERTICES (NUM_VERTICES)
    ) side_judge_i (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .phase     (phase),
        .point_idx (point_idx),
        .positive  (positive),
        .is_inside (is_inside)
    );

endmodule

// ==== dv/geofence_tb_clock.sv ====
/*
 * Clock and reset source for the geofence testbench.
 * Period of 4 time units, reset high for the first 8 rising edges.
 */
module geofence_tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release lands on a rising edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== dv/geofence_tb.sv ====
/*
 * Testbench for the geofence checker at default sizes.
 * Four fixed hexagon runs, then twenty random runs fed back to back.
 */
module geofence_tb;

    localparam int COORD_W     = geofence_pkg::DEFAULT_COORD_W;
    localparam int NV          = geofence_pkg::DEFAULT_NUM_VERTICES;
    localparam int NUM_RUNS    = 24;
    localparam int LATENCY     = 3 * (NV - 1) * (NV - 2) / 2 + 3 * NV + 1;
    localparam int CYCLE_LIMIT = NUM_RUNS * (NV + 1 + LATENCY) + 100;

    logic               clk;
    logic               reset;
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic               ready;
    logic               valid;
    logic               is_inside;

    int    run_tx [NUM_RUNS];
    int    run_ty [NUM_RUNS];
    int    run_vx [NUM_RUNS][NV];
    int    run_vy [NUM_RUNS][NV];
    logic  run_exp [NUM_RUNS];
    string run_name [NUM_RUNS];

    logic [15:0] lfsr_state = 16'd48247;
    int   errors = 0;
    int   err_base = 0;
    int   runs_ok = 0;
    int   results_seen = 0;
    int   cycle_no = 0;
    int   tick_count = 0;
    int   ready_len = 0;
    int   last_sample = 0;
    logic valid_seen = 1'b0;

    geofence_tb_clock clock_i (.clk(clk), .reset(reset));

    geofence dut_i (
        .clk       (clk),
        .reset     (reset),
        .x         (x),
        .y         (y),
        .ready     (ready),
        .valid     (valid),
        .is_inside (is_inside)
    );

    // galois form with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic int take_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // pairwise sort around vertex 0, then one sign per edge against the target
    function automatic logic ref_inside(input int tx, input int ty,
                                        input int vx_in[NV], input int vy_in[NV]);
        int   vx[NV];
        int   vy[NV];
        int   i;
        int   j;
        int   t;
        logic pos;
        logic all_pos;
        logic all_neg;
        vx = vx_in;
        vy = vy_in;
        for (i = 1; i < NV - 1; i++) begin
            for (j = i + 1; j < NV; j++) begin
                // zero cross product also swaps
                if (!((vx[i] - vx[0]) * (vy[j] - vy[0]) > (vy[i] - vy[0]) * (vx[j] - vx[0]))) begin
                    t = vx[i];
                    vx[i] = vx[j];
                    vx[j] = t;
                    t = vy[i];
                    vy[i] = vy[j];
                    vy[j] = t;
                end
            end
        end
        all_pos = 1'b1;
        all_neg = 1'b1;
        for (i = 0; i < NV; i++) begin
            j = (i + 1) % NV;
            pos = (vx[i] - tx) * (vy[j] - vy[i]) > (vy[i] - ty) * (vx[j] - vx[i]);
            all_pos = all_pos & pos;
            all_neg = all_neg & !pos;
        end
        return all_pos | all_neg;
    endfunction

    task automatic check_inside(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at time %0t: %s is %0b, expected %0b", $time, what, got,
                     expected);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("CHECK FAILED at time %0t: %s is %0d cycles, expected %0d", $time, what,
                     got, expected);
            errors++;
        end
    endtask

    task automatic store_run(input int r, input string name, input int tx, input int ty,
                             input int px[NV], input int py[NV], input logic expected);
        int k;
        run_name[r] = name;
        run_tx[r] = tx;
        run_ty[r] = ty;
        run_exp[r] = expected;
        for (k = 0; k < NV; k++) begin
            run_vx[r][k] = px[k];
            run_vy[r][k] = py[k];
        end
    endtask

    task automatic build_runs();
        int hex_x[NV];
        int hex_y[NV];
        int perm[NV];
        int dir_x[NV];
        int dir_y[NV];
        int px[NV];
        int py[NV];
        int r;
        int k;
        int cx;
        int cy;
        int rad;
        int start;
        int rev;
        int src;
        int tx;
        int ty;
        // counter-clockwise regular hexagon around (512,512)
        hex_x = '{712, 612, 412, 312, 412, 612};
        hex_y = '{512, 685, 685, 512, 339, 339};
        perm = '{4, 0, 3, 1, 5, 2};
        dir_x = '{2, 1, -1, -2, -1, 1};
        dir_y = '{0, 2, 2, 0, -2, -2};
        for (k = 0; k < NV; k++) begin
            px[k] = hex_x[perm[k]];
            py[k] = hex_y[perm[k]];
        end
        store_run(0, "centre, angular order", 512, 512, hex_x, hex_y, 1'b1);
        store_run(1, "outside, angular order", 1000, 1000, hex_x, hex_y, 1'b0);
        store_run(2, "centre, scrambled", 512, 512, px, py, 1'b1);
        store_run(3, "outside, scrambled", 1000, 1000, px, py, 1'b0);
        // jittered hexagons that are rotated and sometimes reversed
        for (r = 4; r < NUM_RUNS; r++) begin
            cx = 256 + take_bits(9);
            cy = 256 + take_bits(9);
            rad = 32 + take_bits(6);
            start = take_bits(3) % NV;
            rev = take_bits(1);
            for (k = 0; k < NV; k++) begin
                src = (rev != 0) ? (start + NV - k) % NV : (start + k) % NV;
                px[k] = cx + dir_x[src] * rad + take_bits(4);
                py[k] = cy + dir_y[src] * rad + take_bits(4);
            end
            tx = cx - 128 + take_bits(8);
            ty = cy - 128 + take_bits(8);
            store_run(r, "random", tx, ty, px, py, ref_inside(tx, ty, px, py));
        end
    endtask

    // holds each point until a ready cycle has taken it
    task automatic feed_run(input int r);
        int p;
        p = 0;
        while (p <= NV) begin
            if (p == 0) begin
                x <= COORD_W'(run_tx[r]);
                y <= COORD_W'(run_ty[r]);
            end else begin
                x <= COORD_W'(run_vx[r][p - 1]);
                y <= COORD_W'(run_vy[r][p - 1]);
            end
            @(negedge clk);
            if (ready) begin
                p = p + 1;
            end
            @(posedge clk);
        end
    endtask

    task automatic report_result();
        int lat;
        if (results_seen >= NUM_RUNS) begin
            $display("valid pulse at time %0t with no run pending", $time);
            errors++;
        end else begin
            lat = cycle_no - last_sample;
            check_inside(is_inside, run_exp[results_seen],
                         $sformatf("run %0d is_inside", results_seen));
            check_latency(lat, LATENCY, $sformatf("run %0d latency", results_seen));
            $display("run %0d (%s): is_inside %0b expected %0b, latency %0d, %s", results_seen,
                     run_name[results_seen], is_inside, run_exp[results_seen], lat,
                     (errors == err_base) ? "ok" : "FAILED");
            if (errors == err_base) begin
                runs_ok++;
            end
            err_base = errors;
            results_seen++;
        end
    endtask

    // compare process sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            cycle_no = cycle_no + 1;
            if (valid_seen) begin
                check_inside(valid, 1'b0, "valid after its pulse");
                check_inside(ready, 1'b1, "ready after valid");
            end
            if (ready) begin
                ready_len = ready_len + 1;
                last_sample = cycle_no;
            end else if (ready_len != 0) begin
                check_latency(ready_len, NV + 1, "ready window");
                ready_len = 0;
            end
            if (valid) begin
                report_result();
            end
            valid_seen = valid;
        end
    end

    always @(posedge clk) begin
        tick_count = tick_count + 1;
        if (tick_count > CYCLE_LIMIT) begin
            $display("timeout: runs not finished after %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int r;
        x = '0;
        y = '0;
        build_runs();
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        // idle cycle right after the release
        check_inside(ready, 1'b0, "ready after reset");
        check_inside(valid, 1'b0, "valid after reset");
        check_inside(is_inside, 1'b0, "is_inside after reset");
        $display("reset: outputs low, %s", (errors == 0) ? "ok" : "FAILED");
        err_base = errors;
        @(posedge clk);
        for (r = 0; r < NUM_RUNS; r++) begin
            feed_run(r);
        end
        while (results_seen < NUM_RUNS) begin
            @(posedge clk);
        end
        // let the check after the last pulse run
        @(negedge clk);
        @(negedge clk);
        $display("runs passed %0d of %0d, errors %0d", runs_ok, NUM_RUNS, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
logic/geofence_pkg.sv
logic/geofence_ctrl.sv
logic/geofence_step_counter.sv
logic/vertex_store.sv
logic/cross_product_unit.sv
logic/side_judge.sv
logic/geofence.sv
dv/geofence_tb_clock.sv
dv/geofence_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the geofence testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module geofence_tb -f files.f \
    -o geofence_sim
out=$(./obj_dir/geofence_sim) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'No errors'; then
    exit 0
fi
exit 1
